// ==== design/srt_div_pkg.sv ====
// opcode and finish-case encodings; case code 2'b11 is unused
package srt_div_pkg;

    // operation carried with each request
    typedef enum logic [1:0] {
        OP_DIVU = 2'b00,
        OP_DIV  = 2'b01,
        OP_REMU = 2'b10,
        OP_REM  = 2'b11
    } div_op_e;

    // how a request gets finished
    // CASE_SMALL means dividend magnitude below divisor magnitude
    typedef enum logic [1:0] {
        CASE_NORMAL   = 2'b00,
        CASE_DIV_ZERO = 2'b01,
        CASE_SMALL    = 2'b10
    } div_case_e;

endpackage

// ==== design/lead_zero_count.sv ====
// combinational only; returns WIDTH for an all-zero input and expects WIDTH of 2 or more
`timescale 1ns/10ps

module lead_zero_count #(
    parameter int WIDTH = 32
) (
    input  logic [WIDTH-1:0]           data,
    output logic [$clog2(WIDTH+1)-1:0] count
);

    localparam int CW     = $clog2(WIDTH + 1);
    localparam int LEVELS = $clog2(WIDTH);
    localparam int P      = 1 << LEVELS;

    // data at the top with zero fill at the low end up to a power of two
    logic [P-1:0] padded;

    assign padded = P'(data) << (P - WIDTH);

    genvar l, j;
    generate
        for (l = 0; l <= LEVELS; l++) begin : lvl
            // per node all-zero flag and leading zero count
            logic          none [P >> l];
            logic [CW-1:0] cnt  [P >> l];
            for (j = 0; j < (P >> l); j++) begin : node
                if (l == 0) begin : leaf
                    assign none[j] = ~padded[j];
                    assign cnt[j]  = '0;
                end else begin : merge
                    assign none[j] = lvl[l-1].none[2*j+1] & lvl[l-1].none[2*j];
                    // upper half empty so count continues into the lower half
                    assign cnt[j]  = lvl[l-1].none[2*j+1]
                                   ? CW'(1 << (l - 1)) + lvl[l-1].cnt[2*j]
                                   : lvl[l-1].cnt[2*j+1];
                end
            end
        end
    endgenerate

    assign count = lvl[LEVELS].none[0] ? CW'(WIDTH) : lvl[LEVELS].cnt[0];

endmodule

// ==== design/srt_decode.sv ====
// operands are taken only on in_valid and in_ready; bypass requests leave with rounds of zero
`timescale 1ns/10ps

module srt_decode
    import srt_div_pkg::*;
#(
    parameter int WIDTH = 32
) (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       in_valid,
    output logic                       in_ready,
    input  div_op_e                    op,
    input  logic [WIDTH-1:0]           dividend,
    input  logic [WIDTH-1:0]           divisor,
    output logic                       dec_valid,
    input  logic                       dec_ready,
    output logic [WIDTH:0]             part_rem,
    output logic [WIDTH:0]             norm_div,
    output logic [$clog2(WIDTH+1)-1:0] rounds,
    output logic [$clog2(WIDTH+1)-1:0] shift_total,
    output logic                       quot_neg,
    output logic                       rem_neg,
    output div_case_e                  div_case,
    output logic [WIDTH-1:0]           orig_dividend,
    output div_op_e                    op_out
);

    localparam int CW = $clog2(WIDTH + 1);

    logic             signed_op;
    logic             a_neg;
    logic             b_neg;
    logic [WIDTH-1:0] a_mag;
    logic [WIDTH-1:0] b_mag;
    logic [CW-1:0]    a_lz;
    logic [CW-1:0]    b_lz;
    logic             is_zero;
    logic             is_small;
    logic             started;
    logic             accept;

    assign signed_op = (op == OP_DIV) || (op == OP_REM);
    assign a_neg     = signed_op && dividend[WIDTH-1];
    assign b_neg     = signed_op && divisor[WIDTH-1];
    assign a_mag     = a_neg ? -dividend : dividend;
    assign b_mag     = b_neg ? -divisor : divisor;

    lead_zero_count #(.WIDTH(WIDTH)) u_lz_dividend (
        .data  (a_mag),
        .count (a_lz)
    );

    lead_zero_count #(.WIDTH(WIDTH)) u_lz_divisor (
        .data  (b_mag),
        .count (b_lz)
    );

    // zero divisor has WIDTH leading zeros
    assign is_zero  = (b_lz == CW'(WIDTH));
    assign is_small = (a_lz > b_lz);

    assign in_ready = started && (!dec_valid || dec_ready);
    assign accept   = in_valid && in_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            started   <= 1'b0;
            dec_valid <= 1'b0;
        end else begin
            started <= 1'b1;
            if (accept) begin
                dec_valid <= 1'b1;
            end else if (dec_ready) begin
                dec_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            part_rem      <= {1'b0, a_mag << a_lz};
            norm_div      <= {1'b0, b_mag << b_lz};
            quot_neg      <= a_neg ^ b_neg;
            rem_neg       <= a_neg;
            orig_dividend <= dividend;
            op_out        <= op;
            // rounds plus the dividend shift is the divisor shift
            shift_total   <= b_lz;
            if (is_zero) begin
                div_case <= CASE_DIV_ZERO;
                rounds   <= '0;
            end else if (is_small) begin
                div_case <= CASE_SMALL;
                rounds   <= '0;
            end else begin
                div_case <= CASE_NORMAL;
                rounds   <= b_lz - a_lz;
            end
        end
    end

endmodule

// ==== design/srt_execute.sv ====
// one SRT digit per cycle for rounds+1 cycles; needs a normalized divisor and WIDTH of 2 or more
`timescale 1ns/10ps

module srt_execute
    import srt_div_pkg::*;
#(
    parameter int WIDTH = 32
) (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       dec_valid,
    output logic                       dec_ready,
    input  logic [WIDTH:0]             part_rem,
    input  logic [WIDTH:0]             norm_div,
    input  logic [$clog2(WIDTH+1)-1:0] rounds,
    input  logic [$clog2(WIDTH+1)-1:0] dec_shift_total,
    input  logic                       dec_quot_neg,
    input  logic                       dec_rem_neg,
    input  div_case_e                  dec_div_case,
    input  logic [WIDTH-1:0]           dec_orig_dividend,
    input  div_op_e                    op,
    output logic                       exe_valid,
    input  logic                       exe_ready,
    output logic [WIDTH:0]             final_rem,
    output logic [WIDTH:0]             final_div,
    output logic [WIDTH-1:0]           pos_q,
    output logic [WIDTH-1:0]           neg_q,
    output logic [$clog2(WIDTH+1)-1:0] shift_total,
    output logic                       quot_neg,
    output logic                       rem_neg,
    output div_case_e                  div_case,
    output logic [WIDTH-1:0]           orig_dividend,
    output div_op_e                    op_out
);

    localparam int CW = $clog2(WIDTH + 1);

    typedef enum logic [1:0] {
        IDLE,
        ITERATE,
        DONE
    } exe_state_e;

    exe_state_e     state;
    logic [CW-1:0]  step_cnt;
    logic [CW-1:0]  last_step;
    logic [WIDTH:0] neg_div;
    logic [WIDTH:0] rem_next;
    logic           digit_pos;
    logic           digit_neg;
    logic           last;
    logic           load;

    assign load      = dec_valid && dec_ready;
    assign last      = (step_cnt == last_step);
    assign dec_ready = (state == IDLE) || ((state == DONE) && exe_ready);
    assign exe_valid = (state == DONE);
    assign neg_div   = -final_div;

    // digit from sign and top magnitude bit
    always_comb begin
        rem_next  = final_rem;
        digit_pos = 1'b0;
        digit_neg = 1'b0;
        case (final_rem[WIDTH -: 2])
            2'b01: begin
                rem_next  = final_rem + neg_div;
                digit_pos = 1'b1;
            end
            2'b10: begin
                rem_next  = final_rem + final_div;
                digit_neg = 1'b1;
            end
            default: rem_next = final_rem;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= IDLE;
            step_cnt <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (dec_valid) begin
                        state <= ITERATE;
                    end
                end
                ITERATE: begin
                    if (last) begin
                        state <= DONE;
                    end
                end
                DONE: begin
                    if (exe_ready) begin
                        state <= dec_valid ? ITERATE : IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
            if (load) begin
                step_cnt <= '0;
            end else if (state == ITERATE) begin
                step_cnt <= step_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            final_rem     <= part_rem;
            final_div     <= norm_div;
            pos_q         <= '0;
            neg_q         <= '0;
            last_step     <= rounds;
            shift_total   <= dec_shift_total;
            quot_neg      <= dec_quot_neg;
            rem_neg       <= dec_rem_neg;
            div_case      <= dec_div_case;
            orig_dividend <= dec_orig_dividend;
            op_out        <= op;
        end else if (state == ITERATE) begin
            // final step keeps the remainder unshifted
            final_rem <= last ? rem_next : {rem_next[WIDTH-1:0], 1'b0};
            pos_q     <= {pos_q[WIDTH-2:0], digit_pos};
            neg_q     <= {neg_q[WIDTH-2:0], digit_neg};
        end
    end

endmodule

// ==== design/srt_result.sv ====
// result is held while out_ready is low; unused opcode-case combinations fall back to the SRT result
`timescale 1ns/10ps

module srt_result
    import srt_div_pkg::*;
#(
    parameter int WIDTH = 32
) (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       exe_valid,
    output logic                       exe_ready,
    input  logic [WIDTH:0]             final_rem,
    input  logic [WIDTH:0]             final_div,
    input  logic [WIDTH-1:0]           pos_q,
    input  logic [WIDTH-1:0]           neg_q,
    input  logic [$clog2(WIDTH+1)-1:0] shift_total,
    input  logic                       quot_neg,
    input  logic                       rem_neg,
    input  div_case_e                  div_case,
    input  logic [WIDTH-1:0]           orig_dividend,
    input  div_op_e                    op,
    output logic                       out_valid,
    input  logic                       out_ready,
    output logic [WIDTH-1:0]           result,
    output logic                       div_zero
);

    logic [WIDTH:0]   rem_fix;
    logic [WIDTH-1:0] rem_mag;
    logic [WIDTH-1:0] quot_mag;
    logic [WIDTH-1:0] rem_val;
    logic [WIDTH-1:0] quot_val;
    logic [WIDTH-1:0] sel;
    logic             is_rem;
    logic             take;

    // negative remainder gets one divisor back and the quotient drops one ulp
    assign rem_fix  = final_rem[WIDTH] ? final_rem + final_div : final_rem;
    assign rem_mag  = rem_fix[WIDTH-1:0] >> shift_total;
    assign quot_mag = pos_q - neg_q - WIDTH'(final_rem[WIDTH]);
    assign rem_val  = rem_neg ? -rem_mag : rem_mag;
    assign quot_val = quot_neg ? -quot_mag : quot_mag;
    assign is_rem   = (op == OP_REMU) || (op == OP_REM);

    always_comb begin
        case (div_case)
            CASE_DIV_ZERO: sel = is_rem ? orig_dividend : '1;
            CASE_SMALL:    sel = is_rem ? orig_dividend : '0;
            default:       sel = is_rem ? rem_val : quot_val;
        endcase
    end

    assign exe_ready = !out_valid || out_ready;
    assign take      = exe_valid && exe_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid <= 1'b0;
        end else if (take) begin
            out_valid <= 1'b1;
        end else if (out_ready) begin
            out_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            result   <= sel;
            div_zero <= (div_case == CASE_DIV_ZERO);
        end
    end

endmodule

// ==== design/srt_div_top.sv ====
// three-stage divider with one request per stage; results leave in request order
`timescale 1ns/10ps

module srt_div_top
    import srt_div_pkg::*;
#(
    parameter int WIDTH = 32
) (
    input  logic             clk,
    input  logic             reset,
    input  logic             in_valid,
    output logic             in_ready,
    input  div_op_e          op,
    input  logic [WIDTH-1:0] dividend,
    input  logic [WIDTH-1:0] divisor,
    output logic             out_valid,
    input  logic             out_ready,
    output logic [WIDTH-1:0] result,
    output logic             div_zero
);

    localparam int CW = $clog2(WIDTH + 1);

    // decode to execute
    logic             dec_valid;
    logic             dec_ready;
    logic [WIDTH:0]   dec_part_rem;
    logic [WIDTH:0]   dec_norm_div;
    logic [CW-1:0]    dec_rounds;
    logic [CW-1:0]    dec_shift_total;
    logic             dec_quot_neg;
    logic             dec_rem_neg;
    div_case_e        dec_div_case;
    logic [WIDTH-1:0] dec_orig_dividend;
    div_op_e          dec_op;

    // execute to result
    logic             exe_valid;
    logic             exe_ready;
    logic [WIDTH:0]   exe_final_rem;
    logic [WIDTH:0]   exe_final_div;
    logic [WIDTH-1:0] exe_pos_q;
    logic [WIDTH-1:0] exe_neg_q;
    logic [CW-1:0]    exe_shift_total;
    logic             exe_quot_neg;
    logic             exe_rem_neg;
    div_case_e        exe_div_case;
    logic [WIDTH-1:0] exe_orig_dividend;
    div_op_e          exe_op;

    srt_decode #(.WIDTH(WIDTH)) u_decode (
        .clk           (clk),
        .reset         (reset),
        .in_valid      (in_valid),
        .in_ready      (in_ready),
        .op            (op),
        .dividend      (dividend),
        .divisor       (divisor),
        .dec_valid     (dec_valid),
        .dec_ready     (dec_ready),
        .part_rem      (dec_part_rem),
        .norm_div      (dec_norm_div),
        .rounds        (dec_rounds),
        .shift_total   (dec_shift_total),
        .quot_neg      (dec_quot_neg),
        .rem_neg       (dec_rem_neg),
        .div_case      (dec_div_case),
        .orig_dividend (dec_orig_dividend),
        .op_out        (dec_op)
    );

    srt_execute #(.WIDTH(WIDTH)) u_execute (
        .clk               (clk),
        .reset             (reset),
        .dec_valid         (dec_valid),
        .dec_ready         (dec_ready),
        .part_rem          (dec_part_rem),
        .norm_div          (dec_norm_div),
        .rounds            (dec_rounds),
        .dec_shift_total   (dec_shift_total),
        .dec_quot_neg      (dec_quot_neg),
        .dec_rem_neg       (dec_rem_neg),
        .dec_div_case      (dec_div_case),
        .dec_orig_dividend (dec_orig_dividend),
        .op                (dec_op),
        .exe_valid         (exe_valid),
        .exe_ready         (exe_ready),
        .final_rem         (exe_final_rem),
        .final_div         (exe_final_div),
        .pos_q             (exe_pos_q),
        .neg_q             (exe_neg_q),
        .shift_total       (exe_shift_total),
        .quot_neg          (exe_quot_neg),
        .rem_neg           (exe_rem_neg),
        .div_case          (exe_div_case),
        .orig_dividend     (exe_orig_dividend),
        .op_out            (exe_op)
    );

    srt_result #(.WIDTH(WIDTH)) u_result (
        .clk           (clk),
        .reset         (reset),
        .exe_valid     (exe_valid),
        .exe_ready     (exe_ready),
        .final_rem     (exe_final_rem),
        .final_div     (exe_final_div),
        .pos_q         (exe_pos_q),
        .neg_q         (exe_neg_q),
        .shift_total   (exe_shift_total),
        .quot_neg      (exe_quot_neg),
        .rem_neg       (exe_rem_neg),
        .div_case      (exe_div_case),
        .orig_dividend (exe_orig_dividend),
        .op            (exe_op),
        .out_valid     (out_valid),
        .out_ready     (out_ready),
        .result        (result),
        .div_zero      (div_zero)
    );

endmodule

// ==== test/srt_div_chk.sv ====
// bound to srt_div_top; the last property also holds the request source to the handshake
`timescale 1ns/10ps

module srt_div_chk
    import srt_div_pkg::*;
#(
    parameter int WIDTH = 32
) (
    input logic             clk,
    input logic             reset,
    input logic             in_valid,
    input logic             in_ready,
    input div_op_e          op,
    input logic [WIDTH-1:0] dividend,
    input logic [WIDTH-1:0] divisor,
    input logic             dec_valid,
    input logic             out_valid,
    input logic             out_ready,
    input logic [WIDTH-1:0] result,
    input logic             div_zero
);

    // nothing valid right after reset
    a_reset_quiet: assert property (@(posedge clk) reset |=> !out_valid && !dec_valid)
        else $error("valid high in the cycle after reset");

    // stalled output keeps its value
    a_out_hold: assert property (@(posedge clk) disable iff (reset)
        out_valid && !out_ready |=> out_valid && $stable(result) && $stable(div_zero))
        else $error("output changed while stalled");

    a_in_hold: assert property (@(posedge clk) disable iff (reset)
        in_valid && !in_ready |=> in_valid && $stable(op) && $stable(dividend)
                                  && $stable(divisor))
        else $error("request dropped or changed before in_ready");

endmodule

// ==== test/srt_div_tb.sv ====
// reads test/srt_div_stim.txt relative to the project root; WIDTH 32 and in-order results
`timescale 1ns/10ps

module srt_div_tb;
    import srt_div_pkg::*;

    localparam int WIDTH     = 32;
    localparam int MAX_REQ   = 256;
    localparam int IN_LIMIT  = 200;
    localparam int OUT_LIMIT = 1000;

    logic             clk;
    logic             reset;
    logic             in_valid;
    logic             in_ready;
    div_op_e          op;
    logic [WIDTH-1:0] dividend;
    logic [WIDTH-1:0] divisor;
    logic             out_valid;
    logic             out_ready;
    logic [WIDTH-1:0] result;
    logic             div_zero;

    // one entry per stimulus line
    logic [3:0]       req_grp  [MAX_REQ];
    logic [1:0]       req_op   [MAX_REQ];
    logic [WIDTH-1:0] req_a    [MAX_REQ];
    logic [WIDTH-1:0] req_b    [MAX_REQ];
    logic [WIDTH-1:0] req_exp  [MAX_REQ];
    logic             req_zero [MAX_REQ];
    int               pending[$];
    int               n_req;
    int               pass_count;
    int               fail_count;
    int               out_count;
    bit               timed_out;
    bit               load_error;
    logic [15:0]      lfsr;

    srt_div_top #(.WIDTH(WIDTH)) uut (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .op        (op),
        .dividend  (dividend),
        .divisor   (divisor),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .result    (result),
        .div_zero  (div_zero)
    );

    bind srt_div_top srt_div_chk #(.WIDTH(WIDTH)) u_chk (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .op        (op),
        .dividend  (dividend),
        .divisor   (divisor),
        .dec_valid (dec_valid),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .result    (result),
        .div_zero  (div_zero)
    );

    always #4 clk = ~clk;

    // galois form with taps 16 14 13 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        lfsr_next = s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    function automatic string group_name(input logic [3:0] g);
        case (g)
            4'd1:    group_name = "unsigned quotient and remainder";
            4'd2:    group_name = "signed sign combinations";
            4'd3:    group_name = "divide by zero";
            4'd4:    group_name = "small dividend and overflow";
            default: group_name = "back-to-back mix";
        endcase
    endfunction

    task automatic load_stimulus();
        int          fd;
        int          cnt;
        string       line;
        logic [31:0] g, o, a, b, e, z;
        fd = $fopen("test/srt_div_stim.txt", "r");
        if (fd == 0) begin
            $display("could not open test/srt_div_stim.txt");
            load_error = 1'b1;
            return;
        end
        while (!$feof(fd) && n_req < MAX_REQ) begin
            line = "";
            cnt  = $fgets(line, fd);
            cnt  = $sscanf(line, "%h %h %h %h %h %h", g, o, a, b, e, z);
            if (cnt == 6) begin
                req_grp[n_req]  = g[3:0];
                req_op[n_req]   = o[1:0];
                req_a[n_req]    = a;
                req_b[n_req]    = b;
                req_exp[n_req]  = e;
                req_zero[n_req] = z[0];
                n_req++;
            end
        end
        $fclose(fd);
        if (n_req == 0) begin
            $display("stimulus file holds no requests");
            load_error = 1'b1;
        end
    endtask

    task automatic drive_requests();
        int i;
        int waited;
        bit done;
        for (i = 0; i < n_req && !timed_out; i++) begin
            @(posedge clk);
            #1;
            in_valid = 1'b1;
            op       = div_op_e'(req_op[i]);
            dividend = req_a[i];
            divisor  = req_b[i];
            waited   = 0;
            done     = 1'b0;
            while (!done && !timed_out) begin
                @(negedge clk);
                if (in_ready) begin
                    done = 1'b1;
                    pending.push_back(i);
                end else if (waited == IN_LIMIT) begin
                    $display("%0t: timed out waiting for in_ready on request %0d", $time, i);
                    timed_out = 1'b1;
                end else begin
                    waited++;
                end
            end
        end
        @(posedge clk);
        #1;
        in_valid = 1'b0;
    endtask

    task automatic check_outputs();
        int   idx;
        int   waited;
        int   g_pass;
        int   g_fail;
        bit   got;
        logic b0;
        g_pass = 0;
        g_fail = 0;
        while (out_count < n_req && !timed_out) begin
            waited = 0;
            got    = 1'b0;
            while (!got && !timed_out) begin
                @(posedge clk);
                #1;
                // two bits per cycle give ready three times in four
                lfsr      = lfsr_next(lfsr);
                b0        = lfsr[0];
                lfsr      = lfsr_next(lfsr);
                out_ready = b0 | lfsr[0];
                @(negedge clk);
                if (out_valid && out_ready) begin
                    got = 1'b1;
                end else if (waited == OUT_LIMIT) begin
                    $display("%0t: timed out waiting for output %0d", $time, out_count);
                    timed_out = 1'b1;
                end else begin
                    waited++;
                end
            end
            if (got) begin
                out_count++;
                if (pending.size() == 0) begin
                    $display("%0t: output appeared with no request outstanding", $time);
                    fail_count++;
                end else begin
                    idx = pending.pop_front();
                    if (result !== req_exp[idx] || div_zero !== req_zero[idx]) begin
                        $display("CHECK FAILED at %0t: req %0d %h / %h got %h %b, want %h %b",
                                 $time, idx, req_a[idx], req_b[idx],
                                 result, div_zero, req_exp[idx], req_zero[idx]);
                        fail_count++;
                        g_fail++;
                    end else begin
                        pass_count++;
                        g_pass++;
                    end
                    if (idx == n_req - 1 || req_grp[idx+1] != req_grp[idx]) begin
                        $display("group %0d %s: %0d passed, %0d failed",
                                 req_grp[idx], group_name(req_grp[idx]), g_pass, g_fail);
                        g_pass = 0;
                        g_fail = 0;
                    end
                end
            end
        end
    endtask

    // drain and watch for duplicates
    task automatic check_no_extra();
        int waited;
        @(posedge clk);
        #1;
        out_ready = 1'b1;
        for (waited = 0; waited < 40; waited++) begin
            @(negedge clk);
            if (out_valid) begin
                $display("%0t: extra output after the last request", $time);
                fail_count++;
                break;
            end
        end
        $display("order and count: %0d outputs for %0d requests", out_count, n_req);
    endtask

    initial begin
        clk        = 1'b0;
        reset      = 1'b1;
        in_valid   = 1'b0;
        op         = OP_DIVU;
        dividend   = '0;
        divisor    = '0;
        out_ready  = 1'b0;
        lfsr       = 16'd16;
        n_req      = 0;
        pass_count = 0;
        fail_count = 0;
        out_count  = 0;
        timed_out  = 1'b0;
        load_error = 1'b0;
        load_stimulus();
        repeat (4) @(posedge clk);
        #1;
        reset = 1'b0;
        if (!load_error) begin
            fork
                drive_requests();
                check_outputs();
            join
            if (!timed_out) begin
                check_no_extra();
            end
        end
        $display("passed %0d, failed %0d", pass_count, fail_count);
        if (fail_count == 0 && !timed_out && !load_error) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

// ==== srt_div.f ====
design/srt_div_pkg.sv
design/lead_zero_count.sv
design/srt_decode.sv
design/srt_execute.sv
design/srt_result.sv
design/srt_div_top.sv
test/srt_div_chk.sv
test/srt_div_tb.sv

// ==== Makefile ====
# Verilator build and run for the SRT divider testbench
VERILATOR ?= verilator
TOP       ?= srt_div_tb
FILELIST  ?= srt_div.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_TEXT ?= TESTS PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)

// ==== test/srt_div_stim.txt ====
// group op dividend divisor expected div_zero, all hex
// op 0 divu, 1 div, 2 remu, 3 rem
1 0 00000064 00000007 0000000E 0
1 2 00000064 00000007 00000002 0
1 0 12345678 00000001 12345678 0
1 0 DEADBEEF DEADBEEF 00000001 0
1 2 DEADBEEF DEADBEEF 00000000 0
1 0 FFFFFFFF 00000010 0FFFFFFF 0
1 2 FFFFFFFF 00000010 0000000F 0
1 0 80000000 00000003 2AAAAAAA 0
1 2 80000000 00000003 00000002 0
1 0 F0000000 7FFFFFFF 00000001 0
1 2 F0000000 7FFFFFFF 70000001 0
2 1 00000064 00000007 0000000E 0
2 3 00000064 00000007 00000002 0
2 1 FFFFFF9C 00000007 FFFFFFF2 0
2 3 FFFFFF9C 00000007 FFFFFFFE 0
2 1 00000064 FFFFFFF9 FFFFFFF2 0
2 3 00000064 FFFFFFF9 00000002 0
2 1 FFFFFF9C FFFFFFF9 0000000E 0
2 3 FFFFFF9C FFFFFFF9 FFFFFFFE 0
2 1 80000001 00000002 C0000001 0
2 3 80000001 00000002 FFFFFFFF 0
2 1 80000000 7FFFFFFF FFFFFFFF 0
2 1 12345678 FFFFFF00 FFEDCBAA 0
2 3 12345678 FFFFFF00 00000078 0
3 0 12345678 00000000 FFFFFFFF 1
3 2 12345678 00000000 12345678 1
3 1 80000000 00000000 FFFFFFFF 1
3 3 FFFFFF9C 00000000 FFFFFF9C 1
4 0 00000000 0000000D 00000000 0
4 2 00000000 0000000D 00000000 0
4 1 FFFFFFFB 00000007 00000000 0
4 3 FFFFFFFB 00000007 FFFFFFFB 0
4 3 00000005 FFFFFFF9 00000005 0
4 2 7FFFFFFF 80000000 7FFFFFFF 0
4 1 80000000 FFFFFFFF 80000000 0
4 3 80000000 FFFFFFFF 00000000 0
5 0 FFFFFFFF 00000001 FFFFFFFF 0
5 1 FFFF0000 00000300 FFFFFFAB 0
5 3 FFFF0000 00000300 FFFFFF00 0
5 0 87654321 00001234 00077023 0
5 2 87654321 00001234 00000605 0
5 0 0000FFFF 000000FF 00000101 0
